/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

  // ====================
  // Basic widths
  // ====================
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_addr_t;

  // Field layout shared by all formats
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } inst_fields_t;

  // ====================
  // Major opcodes
  // ====================
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // Branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // ALU variants with one code shared by SRL and SRA
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // Selects SUB over ADD and SRA over SRL
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

endpackage

/* rtl/core_types_pkg.sv */
package core_types_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // Where the register write value comes from
  typedef enum logic [1:0] {
    WB_ALU,
    WB_IMM,
    WB_PC_IMM,
    WB_PC4
  } wb_sel_e;

  typedef enum logic [3:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU,
    BR_JAL,
    BR_JALR
  } branch_e;

  typedef struct packed {
    rv_isa_pkg::reg_addr_t rs1;
    rv_isa_pkg::reg_addr_t rs2;
    rv_isa_pkg::reg_addr_t rd;
    alu_op_e               alu_op;
    logic                  op_b_imm;
    rv_isa_pkg::xlen_t     imm;
    wb_sel_e               wb_sel;
    logic                  reg_write;
    branch_e               branch;
    logic                  is_ecall;
  } decoded_t;

  // ====================
  // Port records
  // ====================
  typedef struct packed {
    logic              valid;
    rv_isa_pkg::xlen_t addr;
  } fetch_req_t;

  typedef struct packed {
    logic              valid;
    rv_isa_pkg::inst_t inst;
  } fetch_rsp_t;

  typedef struct packed {
    logic                  valid;
    rv_isa_pkg::xlen_t     pc;
    rv_isa_pkg::reg_addr_t rd;
    logic                  reg_write;
    rv_isa_pkg::xlen_t     wdata;
  } commit_t;

endpackage

/* rtl/rv_fetch.sv */
`timescale 1ns/1ps

module rv_fetch #(
  parameter rv_isa_pkg::xlen_t RESET_PC = 32'h0000_0000
) (
  input  logic                       clk,
  input  logic                       rst,
  output core_types_pkg::fetch_req_t imem_req,
  input  core_types_pkg::fetch_rsp_t imem_rsp,
  output rv_isa_pkg::inst_t          inst,
  output rv_isa_pkg::xlen_t          pc,
  output logic                       exec_valid,
  input  rv_isa_pkg::xlen_t          next_pc,
  input  logic                       is_ecall,
  input  logic                       wb_en,
  input  rv_isa_pkg::reg_addr_t      wb_rd,
  input  rv_isa_pkg::xlen_t          wb_data,
  output core_types_pkg::commit_t    commit,
  output logic                       halt
);
  import rv_isa_pkg::*;

  typedef enum logic {S_FETCH, S_WAIT} state_e;

  state_e state;
  xlen_t  pc_q;
  logic   outstanding;
  logic   rsp_accept;

  // In flight once the single request cycle has passed
  assign outstanding = (state == S_WAIT) && !imem_req.valid;
  assign rsp_accept  = imem_rsp.valid && outstanding;

  // Execute sees the response word directly
  assign inst       = imem_rsp.inst;
  assign pc         = pc_q;
  assign exec_valid = rsp_accept;

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= S_FETCH;
      pc_q           <= RESET_PC;
      imem_req.valid <= 1'b0;
      commit.valid   <= 1'b0;
      halt           <= 1'b0;
    end else begin
      imem_req.valid <= 1'b0;
      commit.valid   <= rsp_accept;
      case (state)
        S_FETCH: begin
          // First request after reset
          if (!halt) begin
            imem_req.valid <= 1'b1;
            imem_req.addr  <= pc_q;
            state          <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (rsp_accept) begin
            pc_q <= next_pc;
            if (is_ecall) begin
              // Leaving S_WAIT makes later stray responses harmless
              halt  <= 1'b1;
              state <= S_FETCH;
            end else begin
              imem_req.valid <= 1'b1;
              imem_req.addr  <= next_pc;
            end
          end
        end
        default: state <= S_FETCH;
      endcase
    end
  end

  // Commit record of the retiring instruction
  always_ff @(posedge clk) begin
    if (rsp_accept) begin
      commit.pc        <= pc_q;
      commit.rd        <= wb_rd;
      commit.reg_write <= wb_en;
      commit.wdata     <= wb_data;
    end
  end

  // ====================
  // Protocol checks
  // ====================
  a_rsp_needs_req: assert property (@(posedge clk) disable iff (rst)
    imem_rsp.valid |-> outstanding)
    else $error("fetch response with no request outstanding");

  a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
    halt |-> !imem_req.valid)
    else $error("fetch request issued while halted");

endmodule

/* rtl/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
  input  rv_isa_pkg::inst_t         inst,
  output core_types_pkg::decoded_t  dec
);
  import rv_isa_pkg::*;
  import core_types_pkg::*;

  inst_fields_t f;
  xlen_t        imm_i;
  xlen_t        imm_b;
  xlen_t        imm_j;
  xlen_t        imm_u;
  logic         funct7_zero;
  logic         funct7_alt;

  assign f = inst;

  // ====================
  // Immediates
  // ====================
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};

  assign funct7_zero = (f.funct7 == '0);
  assign funct7_alt  = (f.funct7 == FUNCT7_ALT);

  function automatic alu_op_e alu_op_of(logic [2:0] funct3, logic alt);
    alu_op_e op;
    case (funct3)
      F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      F3_AND:  op = ALU_AND;
      default: op = ALU_ADD;
    endcase
    return op;
  endfunction

  always_comb begin
    // Defaults retire as a no-op
    dec.rs1       = f.rs1;
    dec.rs2       = f.rs2;
    dec.rd        = f.rd;
    dec.alu_op    = ALU_ADD;
    dec.op_b_imm  = 1'b0;
    dec.imm       = '0;
    dec.wb_sel    = WB_ALU;
    dec.reg_write = 1'b0;
    dec.branch    = BR_NONE;
    dec.is_ecall  = 1'b0;

    case (f.opcode)
      OPC_LUI: begin
        dec.imm       = imm_u;
        dec.wb_sel    = WB_IMM;
        dec.reg_write = 1'b1;
      end
      OPC_AUIPC: begin
        dec.imm       = imm_u;
        dec.wb_sel    = WB_PC_IMM;
        dec.reg_write = 1'b1;
      end
      OPC_JAL: begin
        dec.imm       = imm_j;
        dec.wb_sel    = WB_PC4;
        dec.reg_write = 1'b1;
        dec.branch    = BR_JAL;
      end
      OPC_JALR: begin
        if (f.funct3 == '0) begin
          dec.imm       = imm_i;
          dec.wb_sel    = WB_PC4;
          dec.reg_write = 1'b1;
          dec.branch    = BR_JALR;
        end
      end
      OPC_BRANCH: begin
        dec.imm = imm_b;
        case (f.funct3)
          F3_BEQ:  dec.branch = BR_BEQ;
          F3_BNE:  dec.branch = BR_BNE;
          F3_BLT:  dec.branch = BR_BLT;
          F3_BGE:  dec.branch = BR_BGE;
          F3_BLTU: dec.branch = BR_BLTU;
          F3_BGEU: dec.branch = BR_BGEU;
          default: dec.branch = BR_NONE;
        endcase
      end
      OPC_OP_IMM: begin
        dec.imm      = imm_i;
        dec.op_b_imm = 1'b1;
        // funct7 only matters for the shift forms
        dec.alu_op   = alu_op_of(f.funct3, (f.funct3 == F3_SR) && funct7_alt);
        if (f.funct3 == F3_SLL) begin
          dec.reg_write = funct7_zero;
        end else if (f.funct3 == F3_SR) begin
          dec.reg_write = funct7_zero || funct7_alt;
        end else begin
          dec.reg_write = 1'b1;
        end
      end
      OPC_OP: begin
        dec.alu_op    = alu_op_of(f.funct3, funct7_alt);
        dec.reg_write = funct7_zero ||
                        (funct7_alt && (f.funct3 == F3_ADD || f.funct3 == F3_SR));
      end
      OPC_SYSTEM: begin
        dec.is_ecall = (inst[31:7] == '0);
      end
      default: ;
    endcase
  end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_isa_pkg::reg_addr_t rs1,
  input  rv_isa_pkg::reg_addr_t rs2,
  output rv_isa_pkg::xlen_t     rs1_data,
  output rv_isa_pkg::xlen_t     rs2_data,
  input  logic                  we,
  input  rv_isa_pkg::reg_addr_t rd,
  input  rv_isa_pkg::xlen_t     wdata
);
  import rv_isa_pkg::*;

  localparam int NUM_REGS = 32;

  xlen_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // Entry 0 is never written so it reads zero
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  a_x0_zero: assert property (@(posedge clk) disable iff (rst)
    we |=> (regs[0] == '0))
    else $error("x0 holds a nonzero value");

endmodule

/* rtl/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
  input  core_types_pkg::decoded_t dec,
  input  rv_isa_pkg::xlen_t        pc,
  input  rv_isa_pkg::xlen_t        rs1_data,
  input  rv_isa_pkg::xlen_t        rs2_data,
  output rv_isa_pkg::xlen_t        next_pc,
  output logic                     wb_en,
  output rv_isa_pkg::xlen_t        wb_data
);
  import rv_isa_pkg::*;
  import core_types_pkg::*;

  xlen_t      op_b;
  logic [4:0] shamt;
  xlen_t      alu_result;
  xlen_t      pc_plus_4;
  xlen_t      pc_plus_imm;
  xlen_t      jalr_sum;
  logic       taken;

  assign op_b        = dec.op_b_imm ? dec.imm : rs2_data;
  assign shamt       = op_b[4:0];
  assign pc_plus_4   = pc + 32'd4;
  assign pc_plus_imm = pc + dec.imm;
  assign jalr_sum    = rs1_data + dec.imm;

  // ====================
  // ALU
  // ====================
  always_comb begin
    case (dec.alu_op)
      ALU_ADD:  alu_result = rs1_data + op_b;
      ALU_SUB:  alu_result = rs1_data - op_b;
      ALU_SLL:  alu_result = rs1_data << shamt;
      ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
      ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, rs1_data < op_b};
      ALU_XOR:  alu_result = rs1_data ^ op_b;
      ALU_SRL:  alu_result = rs1_data >> shamt;
      ALU_SRA:  alu_result = xlen_t'($signed(rs1_data) >>> shamt);
      ALU_OR:   alu_result = rs1_data | op_b;
      ALU_AND:  alu_result = rs1_data & op_b;
      default:  alu_result = '0;
    endcase
  end

  // Branch condition where JAL is always taken
  always_comb begin
    case (dec.branch)
      BR_BEQ:  taken = (rs1_data == rs2_data);
      BR_BNE:  taken = (rs1_data != rs2_data);
      BR_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
      BR_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      BR_BLTU: taken = (rs1_data < rs2_data);
      BR_BGEU: taken = (rs1_data >= rs2_data);
      BR_JAL:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (dec.branch == BR_JALR) begin
      next_pc = {jalr_sum[XLEN-1:1], 1'b0};
    end else if (taken) begin
      next_pc = pc_plus_imm;
    end else begin
      next_pc = pc_plus_4;
    end
  end

  // ====================
  // Writeback
  // ====================
  always_comb begin
    case (dec.wb_sel)
      WB_ALU:    wb_data = alu_result;
      WB_IMM:    wb_data = dec.imm;
      WB_PC_IMM: wb_data = pc_plus_imm;
      WB_PC4:    wb_data = pc_plus_4;
      default:   wb_data = alu_result;
    endcase
  end

  // x0 writes are dropped here
  assign wb_en = dec.reg_write && (dec.rd != '0);

endmodule

/* rtl/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
  parameter rv_isa_pkg::xlen_t RESET_PC = 32'h0000_0000
) (
  input  logic                       clk,
  input  logic                       rst,
  output core_types_pkg::fetch_req_t imem_req,
  input  core_types_pkg::fetch_rsp_t imem_rsp,
  output core_types_pkg::commit_t    commit,
  output logic                       halt
);
  import rv_isa_pkg::*;
  import core_types_pkg::*;

  inst_t    inst;
  xlen_t    pc;
  logic     exec_valid;
  decoded_t dec;
  xlen_t    rs1_data;
  xlen_t    rs2_data;
  xlen_t    next_pc;
  logic     wb_en;
  xlen_t    wb_data;
  logic     rf_we;

  // Only an accepted response may write registers
  assign rf_we = wb_en && exec_valid;

  rv_fetch #(
    .RESET_PC (RESET_PC)
  ) fetch_inst (
    .clk        (clk),
    .rst        (rst),
    .imem_req   (imem_req),
    .imem_rsp   (imem_rsp),
    .inst       (inst),
    .pc         (pc),
    .exec_valid (exec_valid),
    .next_pc    (next_pc),
    .is_ecall   (dec.is_ecall),
    .wb_en      (wb_en),
    .wb_rd      (dec.rd),
    .wb_data    (wb_data),
    .commit     (commit),
    .halt       (halt)
  );

  rv_decoder decoder_inst (
    .inst (inst),
    .dec  (dec)
  );

  reg_file reg_file_inst (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .rd       (dec.rd),
    .wdata    (wb_data)
  );

  rv_execute execute_inst (
    .dec      (dec),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .next_pc  (next_pc),
    .wb_en    (wb_en),
    .wb_data  (wb_data)
  );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* verification/tb_program.svh */
// Columns are test name, instruction word, expected pc, reg_write, rd, wdata and halt
// Rows are in commit order
// x1 = 5 and x2 = -3 feed the ALU and branch rows
task automatic load_program();
  add_row("addi_x1",    32'h0050_0093, 32'h0000_0100, 1'b1, 5'd1,  32'h0000_0005, 1'b0);
  add_row("addi_neg",   32'hffd0_0113, 32'h0000_0104, 1'b1, 5'd2,  32'hffff_fffd, 1'b0);
  add_row("lui",        32'h1234_51b7, 32'h0000_0108, 1'b1, 5'd3,  32'h1234_5000, 1'b0);
  add_row("auipc",      32'h0000_1217, 32'h0000_010c, 1'b1, 5'd4,  32'h0000_110c, 1'b0);
  add_row("add",        32'h0020_82b3, 32'h0000_0110, 1'b1, 5'd5,  32'h0000_0002, 1'b0);
  add_row("sub",        32'h4020_8333, 32'h0000_0114, 1'b1, 5'd6,  32'h0000_0008, 1'b0);
  add_row("sll",        32'h0020_93b3, 32'h0000_0118, 1'b1, 5'd7,  32'ha000_0000, 1'b0);
  add_row("slt",        32'h0011_2433, 32'h0000_011c, 1'b1, 5'd8,  32'h0000_0001, 1'b0);
  add_row("sltu",       32'h0011_34b3, 32'h0000_0120, 1'b1, 5'd9,  32'h0000_0000, 1'b0);
  add_row("xor",        32'h0020_c533, 32'h0000_0124, 1'b1, 5'd10, 32'hffff_fff8, 1'b0);
  add_row("srl",        32'h0011_55b3, 32'h0000_0128, 1'b1, 5'd11, 32'h07ff_ffff, 1'b0);
  add_row("sra_neg",    32'h4011_5633, 32'h0000_012c, 1'b1, 5'd12, 32'hffff_ffff, 1'b0);
  add_row("or",         32'h0020_e6b3, 32'h0000_0130, 1'b1, 5'd13, 32'hffff_fffd, 1'b0);
  add_row("and",        32'h0020_f733, 32'h0000_0134, 1'b1, 5'd14, 32'h0000_0005, 1'b0);
  add_row("slti",       32'h0011_2793, 32'h0000_0138, 1'b1, 5'd15, 32'h0000_0001, 1'b0);
  add_row("sltiu",      32'h0011_3813, 32'h0000_013c, 1'b1, 5'd16, 32'h0000_0000, 1'b0);
  add_row("xori",       32'hfff0_c893, 32'h0000_0140, 1'b1, 5'd17, 32'hffff_fffa, 1'b0);
  add_row("ori",        32'h0f00_e913, 32'h0000_0144, 1'b1, 5'd18, 32'h0000_00f5, 1'b0);
  add_row("andi",       32'h0ff1_7993, 32'h0000_0148, 1'b1, 5'd19, 32'h0000_00fd, 1'b0);
  add_row("slli",       32'h0040_9a13, 32'h0000_014c, 1'b1, 5'd20, 32'h0000_0050, 1'b0);
  add_row("srli",       32'h01c1_5a93, 32'h0000_0150, 1'b1, 5'd21, 32'h0000_000f, 1'b0);
  add_row("srai_neg",   32'h4011_5b13, 32'h0000_0154, 1'b1, 5'd22, 32'hffff_fffe, 1'b0);
  add_row("write_x0",   32'h0070_8013, 32'h0000_0158, 1'b0, 5'd0,  32'h0000_0000, 1'b0);
  add_row("read_x0",    32'h0010_0bb3, 32'h0000_015c, 1'b1, 5'd23, 32'h0000_0005, 1'b0);
  add_row("beq_taken",  32'h0010_8463, 32'h0000_0160, 1'b0, 5'd0,  32'h0000_0000, 1'b0);
  add_row("beq_not",    32'h0020_8463, 32'h0000_0168, 1'b0, 5'd0,  32'h0000_0000, 1'b0);
  add_row("bne_taken",  32'h0020_9463, 32'h0000_016c, 1'b0, 5'd0,  32'h0000_0000, 1'b0);
  add_row("bne_not",    32'h0010_9463, 32'h0000_0174, 1'b0, 5'd0,  32'h0000_0000, 1'b0);
  add_row("blt_taken",  32'h0011_4463, 32'h0000_0178, 1'b0, 5'd0,  32'h0000_0000, 1'b0);
  add_row("blt_not",    32'h0020_c463, 32'h0000_0180, 1'b0, 5'd0,  32'h0000_0000, 1'b0);
  add_row("bge_taken",  32'h0020_d463, 32'h0000_0184, 1'b0, 5'd0,  32'h0000_0000, 1'b0);
  add_row("bge_not",    32'h0011_5463, 32'h0000_018c, 1'b0, 5'd0,  32'h0000_0000, 1'b0);
  add_row("bltu_taken", 32'h0020_e463, 32'h0000_0190, 1'b0, 5'd0,  32'h0000_0000, 1'b0);
  add_row("bltu_not",   32'h0011_6463, 32'h0000_0198, 1'b0, 5'd0,  32'h0000_0000, 1'b0);
  add_row("bgeu_taken", 32'h0011_7463, 32'h0000_019c, 1'b0, 5'd0,  32'h0000_0000, 1'b0);
  add_row("bgeu_not",   32'h0020_f463, 32'h0000_01a4, 1'b0, 5'd0,  32'h0000_0000, 1'b0);
  add_row("jal",        32'h00c0_0c6f, 32'h0000_01a8, 1'b1, 5'd24, 32'h0000_01ac, 1'b0);
  // Target 0x1bd has bit 0 cleared
  add_row("jalr",       32'h011c_0ce7, 32'h0000_01b4, 1'b1, 5'd25, 32'h0000_01b8, 1'b0);
  add_row("link_sum",   32'h019c_0d33, 32'h0000_01bc, 1'b1, 5'd26, 32'h0000_0364, 1'b0);
  add_row("ecall",      32'h0000_0073, 32'h0000_01c0, 1'b0, 5'd0,  32'h0000_0000, 1'b1);
endtask

/* verification/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;
  import rv_isa_pkg::*;
  import core_types_pkg::*;

  localparam xlen_t RESET_PC     = 32'h0000_0100;
  localparam int    RESET_CYCLES = 16;
  localparam int    MAX_DELAY    = 4;
  localparam int    MARGIN       = 20;
  localparam int    HALT_WATCH   = 20;
  localparam int    ADDR_BITS    = 6;
  localparam int    MEM_WORDS    = 1 << ADDR_BITS;

  typedef struct {
    string   name;
    inst_t   word;
    commit_t exp;
    logic    exp_halt;
  } row_t;

  logic       clk;
  logic       rst;
  fetch_req_t imem_req;
  fetch_rsp_t imem_rsp;
  commit_t    commit;
  logic       halt;

  row_t        rows[$];
  inst_t       mem [MEM_WORDS];
  logic [31:0] lcg_state     = 32'h8d51;
  int          errors        = 0;
  int          tests         = 0;
  int          tests_failed  = 0;
  int          cycle_count   = 0;
  int          timeout_limit = 0;

  tb_clock_gen #(
    .RESET_CYCLES (RESET_CYCLES)
  ) clock_gen_inst (
    .clk (clk),
    .rst (rst)
  );

  rv_core #(
    .RESET_PC (RESET_PC)
  ) rv_core_inst (
    .clk      (clk),
    .rst      (rst),
    .imem_req (imem_req),
    .imem_rsp (imem_rsp),
    .commit   (commit),
    .halt     (halt)
  );

  task automatic add_row(string name, inst_t word, xlen_t pc, logic wr,
                         reg_addr_t rd, xlen_t wdata, logic exp_halt);
    row_t row;
    row.name            = name;
    row.word            = word;
    row.exp.valid       = 1'b1;
    row.exp.pc          = pc;
    row.exp.reg_write   = wr;
    row.exp.rd          = rd;
    row.exp.wdata       = wdata;
    row.exp_halt        = exp_halt;
    rows.push_back(row);
  endtask

  `include "tb_program.svh"

  // ====================
  // Instruction memory
  // ====================
  function automatic logic [31:0] lcg_next(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Opcode 0 decodes as a no-op, so a stray fetch shows up as a pc mismatch
  function automatic inst_t fill_word(logic [ADDR_BITS-1:0] idx);
    return {19'h5_a5a5, idx, 7'h00};
  endfunction

  function automatic inst_t fetch_word(xlen_t addr);
    xlen_t offset;
    offset = addr - RESET_PC;
    if (offset < MEM_WORDS * 4) begin
      return mem[offset[ADDR_BITS+1:2]];
    end
    return '0;
  endfunction

  initial begin : memory_model
    int unsigned delay;
    xlen_t       addr;
    imem_rsp = '0;
    forever begin
      @(negedge clk);
      if (!rst && imem_req.valid) begin
        addr      = imem_req.addr;
        lcg_state = lcg_next(lcg_state);
        delay     = 1 + int'(lcg_state[17:16]);
        repeat (delay) @(posedge clk);
        imem_rsp.inst  <= fetch_word(addr);
        imem_rsp.valid <= 1'b1;
        @(posedge clk);
        imem_rsp.valid <= 1'b0;
      end
    end
  end

  // ====================
  // Checks
  // ====================
  function automatic string commit_text(commit_t c);
    return $sformatf("pc=%h wr=%b rd=x%0d wdata=%h", c.pc, c.reg_write, c.rd, c.wdata);
  endfunction

  // rd and wdata only count when a register is written
  task automatic check_commit(string name, commit_t exp, commit_t act);
    if (act.pc !== exp.pc || act.reg_write !== exp.reg_write ||
        (exp.reg_write && (act.rd !== exp.rd || act.wdata !== exp.wdata))) begin
      $display("[FAIL] %s expected %s actual %s", name, commit_text(exp), commit_text(act));
      errors++;
    end
  endtask

  task automatic check_halt(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("[FAIL] %s halt expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(string name, xlen_t exp, xlen_t act);
    if (act !== exp) begin
      $display("[FAIL] %s address expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(string name, int start_errors);
    tests++;
    if (errors == start_errors) begin
      $display("test %-12s ok", name);
    end else begin
      tests_failed++;
      $display("test %-12s mismatch", name);
    end
  endtask

  initial begin : watchdog
    wait (timeout_limit > 0);
    while (cycle_count < timeout_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the core made no further progress after %0d cycles", cycle_count);
    $display("Simulation FAILED");
    $finish;
  end

  // ====================
  // Test sequence
  // ====================
  initial begin : main
    int start;
    load_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(i[ADDR_BITS-1:0]);
    end
    foreach (rows[i]) begin
      mem[rows[i].exp.pc[ADDR_BITS+1:2] - RESET_PC[ADDR_BITS+1:2]] = rows[i].word;
    end
    timeout_limit = rows.size() * (MAX_DELAY + 2) + RESET_CYCLES + MARGIN;

    // Outputs stay quiet while reset is held
    start = errors;
    @(posedge clk);
    while (rst) begin
      @(negedge clk);
      if (rst) begin
        check_halt("reset_state", 1'b0, halt);
        check_flag("reset_state request", 1'b0, imem_req.valid);
        check_flag("reset_state commit", 1'b0, commit.valid);
      end
    end
    finish_test("reset_state", start);

    start = errors;
    do @(negedge clk); while (!imem_req.valid);
    check_addr("first_fetch", RESET_PC, imem_req.addr);
    finish_test("first_fetch", start);

    // One commit per row, in program order
    foreach (rows[i]) begin
      start = errors;
      do @(negedge clk); while (!commit.valid);
      check_commit(rows[i].name, rows[i].exp, commit);
      check_halt(rows[i].name, rows[i].exp_halt, halt);
      finish_test(rows[i].name, start);
    end

    start = errors;
    repeat (HALT_WATCH) begin
      @(negedge clk);
      check_flag("halt_quiet request", 1'b0, imem_req.valid);
      check_flag("halt_quiet commit", 1'b0, commit.valid);
      check_halt("halt_quiet", 1'b1, halt);
    end
    finish_test("halt_quiet", start);

    $display("%0d tests, %0d failed, %0d check errors", tests, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+verification
rtl/rv_isa_pkg.sv
rtl/core_types_pkg.sv
rtl/rv_fetch.sv
rtl/rv_decoder.sv
rtl/reg_file.sv
rtl/rv_execute.sv
rtl/rv_core.sv
verification/tb_clock_gen.sv
verification/tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the RV32I core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f all.f --top-module tb_rv_core -o tb_rv_core \
  && ./obj_dir/tb_rv_core > sim.log 2>&1 \
  || echo "Build or simulation stopped with an error"

cat sim.log 2>/dev/null
grep -qx "Simulation PASSED" sim.log || exit 1
exit 0
